// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Which architectural state an instruction updates
    typedef struct packed {
        logic write_reg;
        logic write_lo;
        logic write_hi;
    } control_t;

    // One instruction as it travels down the pipeline
    typedef struct packed {
        logic     valid;
        word_t    instruction;
        reg_idx_t dest_reg;
        word_t    dest_reg_data;
        word_t    dest_lo_data;
        word_t    dest_hi_data;
        control_t control;
    } pipeline_signal_t;

    typedef struct packed {
        logic  f;      // Set when a newer record supplies the value
        word_t data;
    } forward_element_t;

    typedef struct packed {
        forward_element_t rs;
        forward_element_t rt;
        forward_element_t lo;
        forward_element_t hi;
    } forward_info_t;

    typedef struct packed {
        word_t rs_data;
        word_t rt_data;
        word_t lo_data;
        word_t hi_data;
    } operands_t;

    function automatic reg_idx_t rs_field(input word_t instruction);
        return instruction[25:21];
    endfunction

    function automatic reg_idx_t rt_field(input word_t instruction);
        return instruction[20:16];
    endfunction

    function automatic pipeline_signal_t bubble();
        return '0;
    endfunction

endpackage

// ==== rtl/register_file.sv ====
module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::reg_idx_t         read_rs,
    input  mips_pkg::reg_idx_t         read_rt,
    input  mips_pkg::pipeline_signal_t write_back,
    input  mips_pkg::pipeline_signal_t memory,
    output mips_pkg::word_t            rs_data,
    output mips_pkg::word_t            rt_data,
    output mips_pkg::word_t            lo_data,
    output mips_pkg::word_t            hi_data
);

    mips_pkg::word_t regs [1:31];  // Register 0 has no storage
    mips_pkg::word_t lo_reg;
    mips_pkg::word_t hi_reg;

    logic gpr_write;
    logic lo_write;
    logic hi_write;

    // General registers commit from write-back, lo and hi one stage earlier
    assign gpr_write = write_back.valid && write_back.control.write_reg
                       && (write_back.dest_reg != '0);
    assign lo_write  = memory.valid && memory.control.write_lo;
    assign hi_write  = memory.valid && memory.control.write_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
            lo_reg <= '0;
            hi_reg <= '0;
        end else begin
            if (gpr_write) begin
                regs[write_back.dest_reg] <= write_back.dest_reg_data;
            end
            if (lo_write) begin
                lo_reg <= memory.dest_lo_data;
            end
            if (hi_write) begin
                hi_reg <= memory.dest_hi_data;
            end
        end
    end

    // Reads see the old value during a write; the forwarder covers that case
    assign rs_data = (read_rs == '0) ? '0 : regs[read_rs];
    assign rt_data = (read_rt == '0) ? '0 : regs[read_rt];
    assign lo_data = lo_reg;
    assign hi_data = hi_reg;

endmodule

// ==== rtl/main_forwarder.sv ====
module main_forwarder (
    input  mips_pkg::pipeline_signal_t ps_decode,
    input  mips_pkg::pipeline_signal_t ps_execute,
    input  mips_pkg::pipeline_signal_t ps_memory,
    input  mips_pkg::pipeline_signal_t ps_write_back,
    output mips_pkg::forward_info_t    decode_forward_info,
    output mips_pkg::forward_info_t    execute_forward_info
);

    mips_pkg::reg_idx_t decode_rs;
    mips_pkg::reg_idx_t decode_rt;
    mips_pkg::reg_idx_t execute_rs;
    mips_pkg::reg_idx_t execute_rt;
    mips_pkg::forward_element_t lo_element;
    mips_pkg::forward_element_t hi_element;

    assign decode_rs  = mips_pkg::rs_field(ps_decode.instruction);
    assign decode_rt  = mips_pkg::rt_field(ps_decode.instruction);
    assign execute_rs = mips_pkg::rs_field(ps_execute.instruction);
    assign execute_rt = mips_pkg::rt_field(ps_execute.instruction);

    // A miss leaves the data cleared as well
    function automatic mips_pkg::forward_element_t make_element(
        input logic            hit,
        input mips_pkg::word_t data
    );
        mips_pkg::forward_element_t element;
        element = '0;
        if (hit) begin
            element.f    = 1'b1;
            element.data = data;
        end
        return element;
    endfunction

    function automatic mips_pkg::forward_element_t gpr_hit(
        input mips_pkg::pipeline_signal_t ps,
        input mips_pkg::reg_idx_t         source
    );
        logic hit;
        hit = ps.valid && ps.control.write_reg && (ps.dest_reg != '0)
              && (ps.dest_reg == source);
        return make_element(hit, ps.dest_reg_data);
    endfunction

    // lo and hi commit when leaving memory, so memory is the only source
    assign lo_element = make_element(ps_memory.valid && ps_memory.control.write_lo,
                                     ps_memory.dest_lo_data);
    assign hi_element = make_element(ps_memory.valid && ps_memory.control.write_hi,
                                     ps_memory.dest_hi_data);

    always_comb begin
        execute_forward_info.rs = gpr_hit(ps_memory, execute_rs);
        if (!execute_forward_info.rs.f) begin
            execute_forward_info.rs = gpr_hit(ps_write_back, execute_rs);
        end
        execute_forward_info.rt = gpr_hit(ps_memory, execute_rt);
        if (!execute_forward_info.rt.f) begin
            execute_forward_info.rt = gpr_hit(ps_write_back, execute_rt);
        end
        execute_forward_info.lo = lo_element;
        execute_forward_info.hi = hi_element;

        // Newer records get picked up again once decode moves to execute
        decode_forward_info.rs = gpr_hit(ps_write_back, decode_rs);
        decode_forward_info.rt = gpr_hit(ps_write_back, decode_rt);
        decode_forward_info.lo = lo_element;
        decode_forward_info.hi = hi_element;
    end

endmodule

// ==== rtl/pipeline_stages.sv ====
module pipeline_stages (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::pipeline_signal_t issue,
    input  mips_pkg::operands_t        regfile_operands,
    input  mips_pkg::forward_info_t    decode_forward_info,
    input  mips_pkg::forward_info_t    execute_forward_info,
    output mips_pkg::pipeline_signal_t ps_decode,
    output mips_pkg::pipeline_signal_t ps_execute,
    output mips_pkg::pipeline_signal_t ps_memory,
    output mips_pkg::pipeline_signal_t ps_write_back,
    output mips_pkg::operands_t        execute_operands
);

    mips_pkg::operands_t decode_operands;
    mips_pkg::operands_t captured_operands;  // Decode values as seen one cycle ago

    // Each forwarded element replaces the matching operand on a hit
    function automatic mips_pkg::operands_t merge(
        input mips_pkg::operands_t     base,
        input mips_pkg::forward_info_t fwd
    );
        mips_pkg::operands_t result;
        result = base;
        if (fwd.rs.f) begin
            result.rs_data = fwd.rs.data;
        end
        if (fwd.rt.f) begin
            result.rt_data = fwd.rt.data;
        end
        if (fwd.lo.f) begin
            result.lo_data = fwd.lo.data;
        end
        if (fwd.hi.f) begin
            result.hi_data = fwd.hi.data;
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            ps_decode     <= mips_pkg::bubble();
            ps_execute    <= mips_pkg::bubble();
            ps_memory     <= mips_pkg::bubble();
            ps_write_back <= mips_pkg::bubble();
        end else begin
            // An invalid issue enters as a clean bubble
            ps_decode     <= issue.valid ? issue : mips_pkg::bubble();
            ps_execute    <= ps_decode;
            ps_memory     <= ps_execute;
            ps_write_back <= ps_memory;
        end
    end

    assign decode_operands = merge(regfile_operands, decode_forward_info);

    always_ff @(posedge clk) begin
        captured_operands <= decode_operands;
    end

    // Memory and write-back now hold the records that were newer than the capture
    assign execute_operands = merge(captured_operands, execute_forward_info);

endmodule

// ==== rtl/operand_path.sv ====
module operand_path (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::pipeline_signal_t issue,
    output mips_pkg::pipeline_signal_t execute_record,
    output mips_pkg::operands_t        execute_operands
);

    mips_pkg::pipeline_signal_t ps_decode;
    mips_pkg::pipeline_signal_t ps_execute;
    mips_pkg::pipeline_signal_t ps_memory;
    mips_pkg::pipeline_signal_t ps_write_back;
    mips_pkg::forward_info_t    decode_forward_info;
    mips_pkg::forward_info_t    execute_forward_info;
    mips_pkg::operands_t        regfile_operands;
    mips_pkg::word_t            rf_rs_data;
    mips_pkg::word_t            rf_rt_data;
    mips_pkg::word_t            rf_lo_data;
    mips_pkg::word_t            rf_hi_data;

    assign regfile_operands = '{rs_data: rf_rs_data, rt_data: rf_rt_data,
                                lo_data: rf_lo_data, hi_data: rf_hi_data};
    assign execute_record   = ps_execute;

    pipeline_stages u_stages (
        .clk                  (clk),
        .reset                (reset),
        .issue                (issue),
        .regfile_operands     (regfile_operands),
        .decode_forward_info  (decode_forward_info),
        .execute_forward_info (execute_forward_info),
        .ps_decode            (ps_decode),
        .ps_execute           (ps_execute),
        .ps_memory            (ps_memory),
        .ps_write_back        (ps_write_back),
        .execute_operands     (execute_operands)
    );

    // Decode reads its sources here
    register_file u_register_file (
        .clk        (clk),
        .reset      (reset),
        .read_rs    (mips_pkg::rs_field(ps_decode.instruction)),
        .read_rt    (mips_pkg::rt_field(ps_decode.instruction)),
        .write_back (ps_write_back),
        .memory     (ps_memory),
        .rs_data    (rf_rs_data),
        .rt_data    (rf_rt_data),
        .lo_data    (rf_lo_data),
        .hi_data    (rf_hi_data)
    );

    main_forwarder u_forwarder (
        .ps_decode            (ps_decode),
        .ps_execute           (ps_execute),
        .ps_memory            (ps_memory),
        .ps_write_back        (ps_write_back),
        .decode_forward_info  (decode_forward_info),
        .execute_forward_info (execute_forward_info)
    );

endmodule

// ==== verif/operand_checker.sv ====
module operand_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::pipeline_signal_t issue,
    input  mips_pkg::pipeline_signal_t execute_record,
    input  mips_pkg::operands_t        execute_operands,
    input  logic                       test_done,
    input  int                         test_index,
    output int                         check_count,
    output int                         error_count,
    output int                         pending
);
    timeunit 1ns;
    timeprecision 1ps;

    mips_pkg::word_t            shadow [32];  // Architectural registers in program order
    mips_pkg::word_t            shadow_lo;
    mips_pkg::word_t            shadow_hi;
    mips_pkg::operands_t        expected_ops [$];
    mips_pkg::pipeline_signal_t expected_rec [$];
    int                         expected_edge [$];
    int                         edge_count;
    int                         test_start_checks;
    int                         test_start_errors;

    initial begin
        check_count       = 0;
        error_count       = 0;
        test_start_checks = 0;
        test_start_errors = 0;
    end

    task automatic compare_word(input string name, input mips_pkg::word_t expected,
                                input mips_pkg::word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Operands are taken before the record's own writes are applied
    task automatic model_record(input mips_pkg::pipeline_signal_t rec);
        mips_pkg::operands_t ops;
        mips_pkg::reg_idx_t  rs;
        mips_pkg::reg_idx_t  rt;
        rs = mips_pkg::rs_field(rec.instruction);
        rt = mips_pkg::rt_field(rec.instruction);
        ops.rs_data = (rs == 5'd0) ? 32'd0 : shadow[rs];
        ops.rt_data = (rt == 5'd0) ? 32'd0 : shadow[rt];
        ops.lo_data = shadow_lo;
        ops.hi_data = shadow_hi;
        expected_ops.push_back(ops);
        expected_rec.push_back(rec);
        expected_edge.push_back(edge_count + 2);  // Decode next cycle, execute the one after
        if (rec.control.write_reg && rec.dest_reg != 5'd0) begin
            shadow[rec.dest_reg] = rec.dest_reg_data;
        end
        if (rec.control.write_lo) begin
            shadow_lo = rec.dest_lo_data;
        end
        if (rec.control.write_hi) begin
            shadow_hi = rec.dest_hi_data;
        end
    endtask

    task automatic check_execute();
        mips_pkg::operands_t        ops;
        mips_pkg::pipeline_signal_t rec;
        int                         due;
        if (execute_record.valid) begin
            if (expected_ops.size() == 0) begin
                error_count++;
                $display("At %0d ns the execute stage shows a valid record that was never issued",
                         $time);
            end else begin
                ops = expected_ops.pop_front();
                rec = expected_rec.pop_front();
                due = expected_edge.pop_front();
                if (due != edge_count) begin
                    error_count++;
                    $display("At %0d ns instruction %h reached execute in the wrong cycle",
                             $time, rec.instruction);
                end
                compare_word("execute_record.instruction", rec.instruction,
                             execute_record.instruction);
                compare_word("execute_record.dest_reg", 32'(rec.dest_reg),
                             32'(execute_record.dest_reg));
                compare_word("execute_record.dest_reg_data", rec.dest_reg_data,
                             execute_record.dest_reg_data);
                compare_word("execute_record.dest_lo_data", rec.dest_lo_data,
                             execute_record.dest_lo_data);
                compare_word("execute_record.dest_hi_data", rec.dest_hi_data,
                             execute_record.dest_hi_data);
                compare_word("execute_record.control", 32'(rec.control),
                             32'(execute_record.control));
                compare_word("execute_operands.rs_data", ops.rs_data, execute_operands.rs_data);
                compare_word("execute_operands.rt_data", ops.rt_data, execute_operands.rt_data);
                compare_word("execute_operands.lo_data", ops.lo_data, execute_operands.lo_data);
                compare_word("execute_operands.hi_data", ops.hi_data, execute_operands.hi_data);
            end
        end else if (expected_ops.size() != 0 && expected_edge[0] <= edge_count) begin
            error_count++;
            $display("At %0d ns instruction %h never showed up in execute",
                     $time, expected_rec[0].instruction);
            void'(expected_ops.pop_front());
            void'(expected_rec.pop_front());
            void'(expected_edge.pop_front());
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            shadow_lo  = '0;
            shadow_hi  = '0;
            edge_count = 0;
            expected_ops.delete();
            expected_rec.delete();
            expected_edge.delete();
        end else begin
            edge_count++;
            check_execute();
            if (issue.valid) begin
                model_record(issue);
            end
            if (test_done) begin
                $display("Test %0d finished: %0d checks, %0d errors", test_index,
                         check_count - test_start_checks, error_count - test_start_errors);
                test_start_checks = check_count;
                test_start_errors = error_count;
            end
        end
        pending = expected_ops.size();
    end

endmodule

// ==== verif/tb_operand_path.sv ====
module tb_operand_path;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_tests        = 6;
    localparam int records_per_test = 80;
    localparam int cycle_limit      = num_tests * records_per_test + 10 * num_tests + 20;

    logic                       clk;
    logic                       reset;
    mips_pkg::pipeline_signal_t issue;
    mips_pkg::pipeline_signal_t execute_record;
    mips_pkg::operands_t        execute_operands;
    logic                       test_done;
    int                         test_index;
    int                         check_count;
    int                         error_count;
    int                         pending;
    int                         cycle_count = 0;

    operand_path u_dut (
        .clk              (clk),
        .reset            (reset),
        .issue            (issue),
        .execute_record   (execute_record),
        .execute_operands (execute_operands)
    );

    operand_checker u_checker (
        .clk              (clk),
        .reset            (reset),
        .issue            (issue),
        .execute_record   (execute_record),
        .execute_operands (execute_operands),
        .test_done        (test_done),
        .test_index       (test_index),
        .check_count      (check_count),
        .error_count      (error_count),
        .pending          (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // A small register set keeps dependencies dense
    function automatic mips_pkg::reg_idx_t pick_reg();
        int unsigned idx;
        idx = $urandom_range(7, 0);
        return (idx < 4) ? 5'(idx) : 5'(idx + 24);
    endfunction

    // Bubbles keep random payload and flags, which the DUT has to ignore
    function automatic mips_pkg::pipeline_signal_t random_record(input int bubble_pct,
            input int reg_pct, input int lohi_pct);
        mips_pkg::pipeline_signal_t rec;
        rec.instruction        = $urandom();
        rec.instruction[25:21] = pick_reg();
        rec.instruction[20:16] = pick_reg();
        rec.dest_reg           = pick_reg();
        rec.dest_reg_data      = $urandom();
        rec.dest_lo_data       = $urandom();
        rec.dest_hi_data       = $urandom();
        rec.control.write_reg  = ($urandom_range(99, 0) < reg_pct);
        rec.control.write_lo   = ($urandom_range(99, 0) < lohi_pct);
        rec.control.write_hi   = ($urandom_range(99, 0) < lohi_pct);
        rec.valid              = ($urandom_range(99, 0) >= bubble_pct);
        return rec;
    endfunction

    task automatic run_test(input int index, input int bubble_pct, input int reg_pct,
                            input int lohi_pct);
        test_index = index;
        repeat (records_per_test) begin
            @(posedge clk);
            #1 issue = random_record(bubble_pct, reg_pct, lohi_pct);
        end
        @(posedge clk);
        #1 issue = mips_pkg::bubble();
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        test_done = 1'b1;
        @(posedge clk);
        #1 test_done = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hb629));
        reset      = 1'b1;
        issue      = mips_pkg::bubble();
        test_done  = 1'b0;
        test_index = 0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        run_test(0, 0, 90, 30);    // Back-to-back chains, first reads see the reset state
        run_test(1, 0, 90, 80);    // Frequent lo and hi writes, often only one of them
        run_test(2, 35, 80, 40);   // Dependencies across bubbles
        run_test(3, 0, 15, 10);    // Sparse writes so most reads come from the register file
        run_test(4, 20, 60, 50);
        run_test(5, 50, 100, 100);
        repeat (2) @(posedge clk);
        #1 $display("All tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/mips_pkg.sv
rtl/register_file.sv
rtl/main_forwarder.sv
rtl/pipeline_stages.sv
rtl/operand_path.sv
verif/operand_checker.sv
verif/tb_operand_path.sv

// ==== Bender.yml ====
package:
  name: operand_path

sources:
  - rtl/mips_pkg.sv
  - rtl/register_file.sv
  - rtl/main_forwarder.sv
  - rtl/pipeline_stages.sv
  - rtl/operand_path.sv
  - target: test
    files:
      - verif/operand_checker.sv
      - verif/tb_operand_path.sv
